//--- Bender.yml
package:
  name: aluExec

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - aluPkg.sv
      - aluControl.sv
      - aluAdder.sv
      - aluBitwise.sv
      - aluCondEval.sv
      - aluFlags.sv
      - aluRetire.sv
      - aluExec.sv
  - target: test
    include_dirs:
      - .
    files:
      - aluExecTb.sv

//--- aluAdder.sv
/*
  ALU adder/subtractor.
  One 64 bit carry chain; subtract adds the inverted operand with
  carry in. Carries at the width boundaries and bit 3 are tapped,
  overflow is taken at the selected width and the sum is masked.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluAdder (
  input  aluPkg::dataWord  a,
  input  aluPkg::dataWord  b,
  input  logic             subtract,
  input  aluPkg::opWidth   width,
  output aluPkg::dataWord  sum,
  output aluPkg::carryTaps taps,
  output logic             overflow
);

  aluPkg::dataWord bEff;
  aluPkg::dataWord raw;
  aluPkg::dataWord carryIn; // carry into each bit
  logic            carryOut;
  logic            signA;
  logic            signB;
  logic            signR;

  assign bEff = subtract ? ~b : b;

  assign {carryOut, raw} = {1'b0, a} + {1'b0, bEff} + (`ALU_DATA_WIDTH+1)'(subtract);

  // carry into bit k+1 is the carry out of bit k
  assign carryIn = a ^ bEff ^ raw;

  assign taps = {carryOut, carryIn[32], carryIn[16], carryIn[8], carryIn[4]};

  assign signA = aluPkg::topBit(a, width);
  assign signB = aluPkg::topBit(bEff, width);
  assign signR = aluPkg::topBit(raw, width);

  // like signs in, different sign out
  assign overflow = (signA == signB) && (signR != signA);

  assign sum = raw & aluPkg::widthMask(width);

endmodule

//--- aluBitwise.sv
/*
  ALU bitwise and move datapath.
  Logic ops masked to the operand width, plain move, zero and
  sign extension from srcB, and the condition driven CMOV/CSET.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluBitwise (
  input  aluPkg::dataWord  a,
  input  aluPkg::dataWord  b,
  input  aluPkg::bitwiseFn fnSel,
  input  aluPkg::opWidth   width,
  input  logic             condTrue,
  output aluPkg::dataWord  result
);

  aluPkg::dataWord mask;
  aluPkg::dataWord xorVal;

  assign mask = aluPkg::widthMask(width);
  assign xorVal = a ^ b;

  always_comb
  begin
    case (fnSel)
      `OP_AND:
        result = a & b & mask;
      `OP_OR:
        result = (a | b) & mask;
      `OP_XOR:
        result = xorVal & mask;
      `OP_XNOR:
        result = ~xorVal & mask;
      `OP_MOV:
        result = b;
      `OP_ZXT8:
        result = {{(`ALU_DATA_WIDTH-8){1'b0}}, b[7:0]};
      `OP_ZXT16:
        result = {{(`ALU_DATA_WIDTH-16){1'b0}}, b[15:0]};
      `OP_SXT8:
        result = {{(`ALU_DATA_WIDTH-8){b[7]}}, b[7:0]};
      `OP_SXT16:
        result = {{(`ALU_DATA_WIDTH-16){b[15]}}, b[15:0]};
      `OP_SXT32:
        result = {{(`ALU_DATA_WIDTH-32){b[31]}}, b[31:0]};
      `OP_CMOV:
        result = condTrue ? b : a; // full width, no masking
      `OP_CSET:
        result = aluPkg::dataWord'(condTrue);
      default:
        result = '0; // adder ops, result comes from the sum
    endcase
  end

endmodule

//--- aluCondEval.sv
/*
  Condition evaluator.
  Tests one of sixteen condition codes against the incoming
  C,O,A,S,Z,P flags for conditional move and set.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluCondEval (
  input  aluPkg::condCode cond,
  input  aluPkg::flagVec  flags,
  output logic            condTrue
);

  logic c;
  logic o;
  logic s;
  logic z;
  logic p;

  assign c = flags[`FLAG_C_BIT];
  assign o = flags[`FLAG_O_BIT];
  assign s = flags[`FLAG_S_BIT];
  assign z = flags[`FLAG_Z_BIT];
  assign p = flags[`FLAG_P_BIT];

  always_comb
  begin
    case (cond)
      `COND_Z:   condTrue = z;
      `COND_NZ:  condTrue = ~z;
      `COND_S:   condTrue = s;
      `COND_NS:  condTrue = ~s;
      `COND_UGT: condTrue = ~c & ~z;
      `COND_ULE: condTrue = c | z;
      `COND_UGE: condTrue = ~c;
      `COND_ULT: condTrue = c;
      `COND_SGT: condTrue = (s == o) & ~z;
      `COND_SLE: condTrue = (s != o) | z;
      `COND_SGE: condTrue = (s == o);
      `COND_SLT: condTrue = (s != o);
      `COND_O:   condTrue = o;
      `COND_NO:  condTrue = ~o;
      `COND_P:   condTrue = p;
      default:   condTrue = 1'b1; // always
    endcase
  end

endmodule

//--- aluConsts.svh
/*
  Integer execution unit constants.
  Widths, opcodes, operand-width codes, condition codes,
  flag bit positions and flag class encodings.
*/
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

`define ALU_DATA_WIDTH   64
`define ALU_FLAG_WIDTH   6
`define ALU_OPCODE_WIDTH 4
`define ALU_COND_WIDTH   4
`define ALU_WCODE_WIDTH  2
`define ALU_CLASS_WIDTH  2
`define ALU_TAP_COUNT    5

// opcodes, also the bitwise function encoding
`define OP_ADD   4'd0
`define OP_SUB   4'd1
`define OP_AND   4'd2
`define OP_OR    4'd3
`define OP_XOR   4'd4
`define OP_XNOR  4'd5
`define OP_MOV   4'd6
`define OP_ZXT8  4'd7
`define OP_ZXT16 4'd8
`define OP_SXT8  4'd9
`define OP_SXT16 4'd10
`define OP_SXT32 4'd11
`define OP_CMOV  4'd12
`define OP_CSET  4'd13 // highest defined opcode

`define WIDTH_8  2'd0
`define WIDTH_16 2'd1
`define WIDTH_32 2'd2
`define WIDTH_64 2'd3

`define COND_Z      4'd0
`define COND_NZ     4'd1
`define COND_S      4'd2
`define COND_NS     4'd3
`define COND_UGT    4'd4
`define COND_ULE    4'd5
`define COND_UGE    4'd6
`define COND_ULT    4'd7
`define COND_SGT    4'd8
`define COND_SLE    4'd9
`define COND_SGE    4'd10
`define COND_SLT    4'd11
`define COND_O      4'd12
`define COND_NO     4'd13
`define COND_P      4'd14
`define COND_ALWAYS 4'd15

// flag vector is {C,O,A,S,Z,P}
`define FLAG_C_BIT 5
`define FLAG_O_BIT 4
`define FLAG_A_BIT 3
`define FLAG_S_BIT 2
`define FLAG_Z_BIT 1
`define FLAG_P_BIT 0

`define FLAG_CLASS_ARITH 2'd0
`define FLAG_CLASS_LOGIC 2'd1
`define FLAG_CLASS_NONE  2'd2

`endif

//--- aluControl.sv
/*
  ALU operation decoder.
  Turns opcode into adder controls, the bitwise function select
  and the flag class. Moves and extends never write flags.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluControl (
  input  logic            opValid,
  input  aluPkg::opcode   op,
  input  aluPkg::opWidth  width,
  output logic            subtract,
  output logic            useAdder,
  output aluPkg::bitwiseFn fnSel,
  output aluPkg::flagClass flagClassSel
);

  assign fnSel = aluPkg::bitwiseFn'(op); // bitwise unit shares the opcode space

  always_comb
  begin
    subtract = 1'b0;
    useAdder = 1'b0;
    flagClassSel = `FLAG_CLASS_NONE;
    case (op)
      `OP_ADD:
      begin
        useAdder = 1'b1;
        flagClassSel = `FLAG_CLASS_ARITH;
      end
      `OP_SUB:
      begin
        subtract = 1'b1;
        useAdder = 1'b1;
        flagClassSel = `FLAG_CLASS_ARITH;
      end
      `OP_AND, `OP_OR, `OP_XOR, `OP_XNOR:
      begin
        flagClassSel = `FLAG_CLASS_LOGIC;
      end
      // moves, extends, cmov and cset leave flags alone at any width
      `OP_MOV, `OP_ZXT8, `OP_ZXT16, `OP_SXT8, `OP_SXT16, `OP_SXT32,
      `OP_CMOV, `OP_CSET:
      begin
        flagClassSel = `FLAG_CLASS_NONE;
      end
      default:
      begin
        flagClassSel = `FLAG_CLASS_NONE;
      end
    endcase
  end

  // issuer must never send the two unused opcodes
  always_comb
  begin
    if (opValid)
    begin
      assert #0 (op <= `OP_CSET)
        else $error("aluControl: undefined opcode %0d issued at width code %0d", op, width);
    end
  end

endmodule

//--- aluExec.f
+incdir+.
aluPkg.sv
aluControl.sv
aluAdder.sv
aluBitwise.sv
aluCondEval.sv
aluFlags.sv
aluRetire.sv
aluExec.sv
aluExecTb.sv

//--- aluExec.sv
/*
  Integer execution unit top.
  Single cycle ALU with a registered result stage: decode, adder,
  bitwise path, condition evaluation and flag build feed the
  retire registers.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluExec (
  input  logic            clk,
  input  logic            rst,
  input  logic            opValid,
  input  aluPkg::opcode   op,
  input  aluPkg::opWidth  width,
  input  aluPkg::condCode cond,
  input  aluPkg::dataWord srcA,
  input  aluPkg::dataWord srcB,
  input  aluPkg::flagVec  flagsIn,
  output logic            resValid,
  output aluPkg::dataWord result,
  output aluPkg::flagVec  flagsOut,
  output logic            flagsWrite
);

  logic             subtract;
  logic             useAdder;
  aluPkg::bitwiseFn fnSel;
  aluPkg::flagClass flagClassSel;
  logic             condTrue;
  aluPkg::dataWord  sum;
  aluPkg::carryTaps taps;
  logic             overflow;
  aluPkg::dataWord  bitResult;
  aluPkg::flagVec   flagsNext;
  logic             writesFlags;

  aluControl ctrl_i (
    .opValid(opValid), .op(op), .width(width), .subtract(subtract),
    .useAdder(useAdder), .fnSel(fnSel), .flagClassSel(flagClassSel)
  );

  aluCondEval cond_i (.cond(cond), .flags(flagsIn), .condTrue(condTrue));

  aluAdder adder_i (
    .a(srcA), .b(srcB), .subtract(subtract), .width(width),
    .sum(sum), .taps(taps), .overflow(overflow)
  );

  aluBitwise bitwise_i (
    .a(srcA), .b(srcB), .fnSel(fnSel), .width(width),
    .condTrue(condTrue), .result(bitResult)
  );

  aluFlags flags_i (
    .value(sum), .bitResult(bitResult), .useAdder(useAdder), .width(width),
    .subtract(subtract), .taps(taps), .overflow(overflow), .classSel(flagClassSel),
    .flagsIn(flagsIn), .flagsNext(flagsNext), .writesFlags(writesFlags)
  );

  aluRetire retire_i (
    .clk(clk), .rst(rst), .opValid(opValid), .useAdder(useAdder), .sum(sum),
    .bitResult(bitResult), .flagsNext(flagsNext), .writesFlags(writesFlags),
    .resValid(resValid), .result(result), .flagsOut(flagsOut), .flagsWrite(flagsWrite)
  );

endmodule

//--- aluExecVectors.svh
/*
  Fixed stimulus table for the execution unit testbench.
  Arithmetic, logic, move and extend rows with hand worked
  results and flags.
*/
`ifndef ALU_EXEC_VECTORS_SVH
`define ALU_EXEC_VECTORS_SVH

// columns: op, width, cond, srcA, srcB, flagsIn,
//          expected result, expected flags {C,O,A,S,Z,P}, expected flagsWrite
task automatic loadVectors();
  // add and subtract, upper operand bits must be masked away
  addRow(`OP_ADD, `WIDTH_8, `COND_ALWAYS, 64'h1234_5678_9abc_de7f, 64'h1, 6'h00,
         64'h80, 6'b011100, 1'b1);
  addRow(`OP_ADD, `WIDTH_8, `COND_ALWAYS, 64'hff, 64'h1, 6'h00,
         64'h0, 6'b101011, 1'b1);
  addRow(`OP_SUB, `WIDTH_16, `COND_ALWAYS, 64'h0, 64'h1, 6'h00,
         64'hffff, 6'b101101, 1'b1);
  addRow(`OP_SUB, `WIDTH_16, `COND_ALWAYS, 64'h8000, 64'h1, 6'h00,
         64'h7fff, 6'b011001, 1'b1);
  addRow(`OP_ADD, `WIDTH_32, `COND_ALWAYS, 64'haaaa_aaaa_ffff_ffff, 64'h1, 6'h00,
         64'h0, 6'b101011, 1'b1);
  addRow(`OP_ADD, `WIDTH_32, `COND_ALWAYS, 64'h7fff_ffff, 64'h7fff_ffff, 6'h00,
         64'hffff_fffe, 6'b011100, 1'b1);
  addRow(`OP_SUB, `WIDTH_32, `COND_ALWAYS, 64'h1234_5678, 64'h1234_5678, 6'h3f,
         64'h0, 6'b000011, 1'b1);
  addRow(`OP_ADD, `WIDTH_64, `COND_ALWAYS, 64'hffff_ffff_ffff_ffff, 64'h2, 6'h00,
         64'h1, 6'b101000, 1'b1);
  addRow(`OP_ADD, `WIDTH_64, `COND_ALWAYS, 64'h7fff_ffff_ffff_ffff, 64'h1, 6'h00,
         64'h8000_0000_0000_0000, 6'b011101, 1'b1);
  addRow(`OP_SUB, `WIDTH_64, `COND_ALWAYS, 64'h5, 64'h3, 6'h3f,
         64'h2, 6'b000000, 1'b1);
  addRow(`OP_SUB, `WIDTH_8, `COND_ALWAYS, 64'h10, 64'h20, 6'h00,
         64'hf0, 6'b100101, 1'b1);
  addRow(`OP_SUB, `WIDTH_8, `COND_ALWAYS, 64'h80, 64'h1, 6'h00,
         64'h7f, 6'b011000, 1'b1);
  // logic ops clear C, O and A
  addRow(`OP_AND, `WIDTH_64, `COND_ALWAYS, 64'hf0f0_f0f0_f0f0_f0f0, 64'hff00_ff00_ff00_ff00,
         6'h3f, 64'hf000_f000_f000_f000, 6'b000101, 1'b1);
  addRow(`OP_OR, `WIDTH_8, `COND_ALWAYS, 64'hffff_ffff_ffff_ff01, 64'h2, 6'h3f,
         64'h3, 6'b000001, 1'b1);
  addRow(`OP_XOR, `WIDTH_16, `COND_ALWAYS, 64'hdead_0000_0000_1234, 64'h0000_beef_0000_1234,
         6'h3f, 64'h0, 6'b000011, 1'b1);
  addRow(`OP_XNOR, `WIDTH_32, `COND_ALWAYS, 64'h0, 64'hff, 6'h3f,
         64'hffff_ff00, 6'b000101, 1'b1);
  addRow(`OP_AND, `WIDTH_32, `COND_ALWAYS, 64'h8000_0001, 64'h8000_0003, 6'h3f,
         64'h8000_0001, 6'b000100, 1'b1);
  // moves and extends pass flags through
  addRow(`OP_MOV, `WIDTH_8, `COND_ALWAYS, 64'h5555, 64'h0123_4567_89ab_cdef, 6'b101010,
         64'h0123_4567_89ab_cdef, 6'b101010, 1'b0);
  addRow(`OP_ZXT8, `WIDTH_64, `COND_ALWAYS, 64'h0, 64'hffff_ffff_ffff_ff85, 6'b010101,
         64'h85, 6'b010101, 1'b0);
  addRow(`OP_ZXT16, `WIDTH_64, `COND_ALWAYS, 64'h0, 64'h1111_2222_3333_8001, 6'b110011,
         64'h8001, 6'b110011, 1'b0);
  addRow(`OP_SXT8, `WIDTH_64, `COND_ALWAYS, 64'h0, 64'h85, 6'b001100,
         64'hffff_ffff_ffff_ff85, 6'b001100, 1'b0);
  addRow(`OP_SXT16, `WIDTH_16, `COND_ALWAYS, 64'h0, 64'h1234_5678_0000_8000, 6'b111000,
         64'hffff_ffff_ffff_8000, 6'b111000, 1'b0);
  addRow(`OP_SXT32, `WIDTH_64, `COND_ALWAYS, 64'h0, 64'h8765_4321, 6'b000111,
         64'hffff_ffff_8765_4321, 6'b000111, 1'b0);
endtask

`endif

//--- aluExecTb.sv
/*
  Testbench for the integer execution unit.
  Applies a fixed table plus random CMOV/CSET rows back to back
  and checks each result one cycle after issue.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluExecTb;

  typedef struct packed {
    aluPkg::opcode   op;
    aluPkg::opWidth  width;
    aluPkg::condCode cond;
    aluPkg::dataWord a;
    aluPkg::dataWord b;
    aluPkg::flagVec  fin;
    aluPkg::dataWord expRes;
    aluPkg::flagVec  expFlags;
    logic            expWrite;
  } vecRow;

  logic            clk;
  logic            rst;
  logic            opValid;
  aluPkg::opcode   op;
  aluPkg::opWidth  width;
  aluPkg::condCode cond;
  aluPkg::dataWord srcA;
  aluPkg::dataWord srcB;
  aluPkg::flagVec  flagsIn;
  logic            resValid;
  aluPkg::dataWord result;
  aluPkg::flagVec  flagsOut;
  logic            flagsWrite;

  vecRow rows[$];
  int    cycleCount;
  int    cycleLimit;

  aluExec dut_i (
    .clk(clk), .rst(rst), .opValid(opValid), .op(op), .width(width), .cond(cond),
    .srcA(srcA), .srcB(srcB), .flagsIn(flagsIn), .resValid(resValid), .result(result),
    .flagsOut(flagsOut), .flagsWrite(flagsWrite)
  );

  always #2 clk = ~clk;

  task automatic addRow(input aluPkg::opcode o, input aluPkg::opWidth w,
                        input aluPkg::condCode c, input aluPkg::dataWord a,
                        input aluPkg::dataWord b, input aluPkg::flagVec fin,
                        input aluPkg::dataWord expRes, input aluPkg::flagVec expFlags,
                        input logic expWrite);
    rows.push_back({o, w, c, a, b, fin, expRes, expFlags, expWrite});
  endtask

  `include "aluExecVectors.svh"

  // reference condition rules, flags are {C,O,A,S,Z,P}
  function automatic logic condHolds(input aluPkg::condCode c, input aluPkg::flagVec f);
    logic cf;
    logic of;
    logic sf;
    logic zf;
    cf = f[5];
    of = f[4];
    sf = f[2];
    zf = f[1];
    case (c)
      `COND_Z:   return zf;
      `COND_NZ:  return !zf;
      `COND_S:   return sf;
      `COND_NS:  return !sf;
      `COND_UGT: return !cf && !zf;
      `COND_ULE: return cf || zf;
      `COND_UGE: return !cf;
      `COND_ULT: return cf;
      `COND_SGT: return (sf == of) && !zf;
      `COND_SLE: return (sf != of) || zf;
      `COND_SGE: return sf == of;
      `COND_SLT: return sf != of;
      `COND_O:   return of;
      `COND_NO:  return !of;
      `COND_P:   return f[0];
      default:   return 1'b1;
    endcase
  endfunction

  // every condition code for both CMOV and CSET with random flags
  task automatic addCondRows();
    aluPkg::dataWord a;
    aluPkg::dataWord b;
    aluPkg::flagVec  fin;
    aluPkg::opWidth  w;
    logic            hit;
    for (int c = 0; c < 16; c++)
    begin
      a = {$urandom, $urandom};
      b = {$urandom, $urandom};
      fin = aluPkg::flagVec'($urandom);
      w = aluPkg::opWidth'($urandom);
      hit = condHolds(aluPkg::condCode'(c), fin);
      addRow(`OP_CMOV, w, aluPkg::condCode'(c), a, b, fin, hit ? b : a, fin, 1'b0);
      fin = aluPkg::flagVec'($urandom);
      hit = condHolds(aluPkg::condCode'(c), fin);
      addRow(`OP_CSET, w, aluPkg::condCode'(c), a, b, fin, aluPkg::dataWord'(hit), fin, 1'b0);
    end
  endtask

  task automatic checkData(input string name, input aluPkg::dataWord exp,
                           input aluPkg::dataWord act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic checkFlags(input string name, input aluPkg::flagVec exp,
                            input aluPkg::flagVec act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      $display("TESTS FAILED");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic checkIdle();
    checkBit("resValid", 1'b0, resValid);
    checkBit("flagsWrite", 1'b0, flagsWrite);
    checkData("result", '0, result);
  endtask

  task automatic checkRow(input vecRow r);
    checkBit("resValid", 1'b1, resValid);
    checkData("result", r.expRes, result);
    checkFlags("flagsOut", r.expFlags, flagsOut);
    checkBit("flagsWrite", r.expWrite, flagsWrite);
  endtask

  task automatic issue(input vecRow r);
    opValid = 1'b1;
    op = r.op;
    width = r.width;
    cond = r.cond;
    srcA = r.a;
    srcB = r.b;
    flagsIn = r.fin;
  endtask

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("run timed out after %0d cycles without finishing", cycleCount);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    void'($urandom(11824));
    clk = 1'b0;
    rst = 1'b1;
    opValid = 1'b0;
    op = '0;
    width = '0;
    cond = '0;
    srcA = '0;
    srcB = '0;
    flagsIn = '0;
    cycleCount = 0;
    loadVectors();
    addCondRows();
    cycleLimit = 16 + 2 * rows.size() + 64;

    repeat (16)
    begin
      @(negedge clk);
      checkIdle();
    end
    rst = 1'b0;
    @(negedge clk);
    checkIdle(); // first cycle out of reset

    // back to back issue, each row checked one cycle later
    foreach (rows[i])
    begin
      @(negedge clk);
      if (i > 0)
        checkRow(rows[i-1]);
      issue(rows[i]);
    end
    @(negedge clk);
    checkRow(rows[rows.size()-1]);
    opValid = 1'b0;
    @(negedge clk);
    checkBit("resValid", 1'b0, resValid);
    checkBit("flagsWrite", 1'b0, flagsWrite);
    checkData("result", rows[rows.size()-1].expRes, result); // held

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- aluFlags.sv
/*
  ALU flag builder.
  Picks the result source, then forms C,O,A,S,Z,P by the arith
  or logic rules, or passes the incoming flags through unchanged.
  Borrow and auxiliary borrow are the inverted carries.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluFlags (
  input  aluPkg::dataWord  value,
  input  aluPkg::dataWord  bitResult,
  input  logic             useAdder,
  input  aluPkg::opWidth   width,
  input  logic             subtract,
  input  aluPkg::carryTaps taps,
  input  logic             overflow,
  input  aluPkg::flagClass classSel,
  input  aluPkg::flagVec   flagsIn,
  output aluPkg::flagVec   flagsNext,
  output logic             writesFlags
);

  aluPkg::dataWord picked;
  logic            widthCarry;
  logic            carryF;
  logic            auxF;
  logic            signF;
  logic            zeroF;
  logic            parityF;

  assign picked = useAdder ? value : bitResult;

  always_comb
  begin
    case (width)
      `WIDTH_8:  widthCarry = taps[1];
      `WIDTH_16: widthCarry = taps[2];
      `WIDTH_32: widthCarry = taps[3];
      default:   widthCarry = taps[4];
    endcase
  end

  assign carryF  = widthCarry ^ subtract;
  assign auxF    = taps[0] ^ subtract; // out of bit 3
  assign signF   = aluPkg::topBit(picked, width);
  assign zeroF   = ~|picked;           // value already masked to width
  assign parityF = ~^picked[7:0];      // even count of ones

  always_comb
  begin
    case (classSel)
      `FLAG_CLASS_ARITH:
        flagsNext = {carryF, overflow, auxF, signF, zeroF, parityF};
      `FLAG_CLASS_LOGIC:
        flagsNext = {3'b000, signF, zeroF, parityF};
      default:
        flagsNext = flagsIn;
    endcase
  end

  assign writesFlags = (classSel == `FLAG_CLASS_ARITH) || (classSel == `FLAG_CLASS_LOGIC);

endmodule

//--- aluPkg.sv
/*
  Integer execution unit package.
  Shared vector types plus the width helpers used by the datapath.
*/
`include "aluConsts.svh"

package aluPkg;

  typedef logic [`ALU_DATA_WIDTH-1:0]   dataWord;
  typedef logic [`ALU_FLAG_WIDTH-1:0]   flagVec;   // C,O,A,S,Z,P
  typedef logic [`ALU_OPCODE_WIDTH-1:0] opcode;
  typedef logic [`ALU_WCODE_WIDTH-1:0]  opWidth;
  typedef logic [`ALU_COND_WIDTH-1:0]   condCode;
  typedef logic [`ALU_OPCODE_WIDTH-1:0] bitwiseFn; // same codes as opcode
  typedef logic [`ALU_CLASS_WIDTH-1:0]  flagClass;
  typedef logic [`ALU_TAP_COUNT-1:0]    carryTaps; // carries out of 63,31,15,7,3

  // ones below the operand width
  function automatic dataWord widthMask(input opWidth w);
    case (w)
      `WIDTH_8:  widthMask = dataWord'({8{1'b1}});
      `WIDTH_16: widthMask = dataWord'({16{1'b1}});
      `WIDTH_32: widthMask = dataWord'({32{1'b1}});
      default:   widthMask = {`ALU_DATA_WIDTH{1'b1}};
    endcase
  endfunction

  // sign bit at the operand width
  function automatic logic topBit(input dataWord v, input opWidth w);
    case (w)
      `WIDTH_8:  topBit = v[7];
      `WIDTH_16: topBit = v[15];
      `WIDTH_32: topBit = v[31];
      default:   topBit = v[`ALU_DATA_WIDTH-1];
    endcase
  endfunction

endpackage

//--- aluRetire.sv
/*
  ALU result stage.
  Chooses sum or bitwise result and registers result, flags and
  valid. Outputs hold their last values between operations.
*/
`timescale 1ns/1ps
`include "aluConsts.svh"

module aluRetire (
  input  logic            clk,
  input  logic            rst,
  input  logic            opValid,
  input  logic            useAdder,
  input  aluPkg::dataWord sum,
  input  aluPkg::dataWord bitResult,
  input  aluPkg::flagVec  flagsNext,
  input  logic            writesFlags,
  output logic            resValid,
  output aluPkg::dataWord result,
  output aluPkg::flagVec  flagsOut,
  output logic            flagsWrite
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resValid <= 1'b0;
      flagsWrite <= 1'b0;
      result <= '0;
      flagsOut <= '0;
    end
    else
    begin
      resValid <= opValid;
      flagsWrite <= opValid & writesFlags;
      if (opValid)
      begin
        result <= useAdder ? sum : bitResult;
        flagsOut <= flagsNext;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) flagsWrite |-> resValid);

  // fixed one cycle latency, no stalls
  assert property (@(posedge clk) disable iff (rst) opValid |=> resValid);
  assert property (@(posedge clk) disable iff (rst) !opValid |=> !resValid);

endmodule
